//--- alu.sv
`timescale 1ns/100ps

module alu (
        input  logic [isaPkg::aluOpWidth-1:0] operation,
        input  busPkg::wordT                  yData,
        input  busPkg::wordT                  busData,
        output busPkg::pairT                  result
);

        import busPkg::*;
        import isaPkg::*;

        localparam int shiftWidth = $clog2(wordWidth);

        wordT                  lowWord;
        logic                  opKnown;
        logic [shiftWidth-1:0] shiftAmount;

        assign shiftAmount = busData[shiftWidth-1:0];

        ////////////////////////////////////////////////////////////////////////////
        // Operation select
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                lowWord = '0;
                opKnown = 1'b1;
                case (operation)
                        aluOpAnd: lowWord = yData & busData;
                        aluOpOr:  lowWord = yData | busData;
                        aluOpAdd: lowWord = yData + busData;
                        aluOpSub: lowWord = yData - busData;
                        aluOpShr: lowWord = yData >> shiftAmount;  // Logical.
                        aluOpShl: lowWord = yData << shiftAmount;
                        // Unary ops take the bus operand.
                        aluOpNeg: lowWord = -busData;
                        aluOpNot: lowWord = ~busData;
                        default: begin
                                opKnown = 1'b0;
                        end
                endcase
        end

        // Result in the low word, sign fill above.
        always_comb begin
                result = '0;
                if (opKnown) begin
                        result.low  = lowWord;
                        result.high = {wordWidth{lowWord[wordWidth-1]}};
                end
        end

endmodule

//--- busMux.sv
`timescale 1ns/100ps

module busMux (
        input  logic [busPkg::regCount-1:0] regOut,
        input  logic                        BAout,
        input  logic                        PCout,
        input  logic                        MDRout,
        input  logic                        ZHighout,
        input  logic                        Zlowout,
        input  logic                        HIout,
        input  logic                        LOout,
        input  logic                        Cout,
        input  busPkg::wordT                regData [busPkg::regCount],
        input  busPkg::wordT                pcData,
        input  busPkg::wordT                mdrData,
        input  busPkg::pairT                zData,
        input  busPkg::wordT                hiData,
        input  busPkg::wordT                loData,
        input  busPkg::wordT                constExt,
        output busPkg::wordT                busData
);

        import busPkg::*;

        localparam int indexWidth = $clog2(regCount);

        logic [srcWidth-1:0] srcCode;
        logic                srcValid;
        logic [srcWidth-1:0] regIndex;

        ////////////////////////////////////////////////////////////////////////////
        // Out-strobe encoder
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                srcCode  = srcGeneral;
                srcValid = 1'b1;
                if (PCout)         srcCode = srcPC;
                else if (MDRout)   srcCode = srcMDR;
                else if (ZHighout) srcCode = srcZHigh;
                else if (Zlowout)  srcCode = srcZLow;
                else if (HIout)    srcCode = srcHI;
                else if (LOout)    srcCode = srcLO;
                else if (Cout)     srcCode = srcC;
                else if (|regOut) begin
                        for (int i = 0; i < regCount; i++) begin
                                if (regOut[i]) srcCode = srcGeneral + srcWidth'(i);
                        end
                end else begin
                        srcValid = 1'b0;  // Idle bus.
                end
        end

        assign regIndex = srcCode - srcGeneral;

        ////////////////////////////////////////////////////////////////////////////
        // Bus multiplexer
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                busData = '0;
                if (srcValid) begin
                        case (srcCode)
                                srcPC:    busData = pcData;
                                srcMDR:   busData = mdrData;
                                srcZHigh: busData = zData.high;
                                srcZLow:  busData = zData.low;
                                srcHI:    busData = hiData;
                                srcLO:    busData = loData;
                                srcC:     busData = constExt;
                                default: begin
                                        if (!(BAout && regIndex == '0)) begin
                                                busData = regData[regIndex[indexWidth-1:0]];
                                        end
                                end
                        endcase
                end
        end

endmodule

//--- busPkg.sv
package busPkg;

        ////////////////////////////////////////////////////////////////////////////
        // Bus word and register file sizes
        ////////////////////////////////////////////////////////////////////////////

        localparam int wordWidth = 32;
        localparam int regCount  = 16;

        typedef logic [wordWidth-1:0] wordT;

        // Z register pair, high word first.
        typedef struct packed {
                wordT high;
                wordT low;
        } pairT;

        ////////////////////////////////////////////////////////////////////////////
        // Bus source codes
        ////////////////////////////////////////////////////////////////////////////

        localparam int srcWidth = 5;

        localparam logic [srcWidth-1:0] srcGeneral = 5'd0;  // R0 to R15 sit at 0 to 15.
        localparam logic [srcWidth-1:0] srcPC      = 5'd16;
        localparam logic [srcWidth-1:0] srcMDR     = 5'd17;
        localparam logic [srcWidth-1:0] srcZHigh   = 5'd18;
        localparam logic [srcWidth-1:0] srcZLow    = 5'd19;
        localparam logic [srcWidth-1:0] srcHI      = 5'd20;
        localparam logic [srcWidth-1:0] srcLO      = 5'd21;
        localparam logic [srcWidth-1:0] srcC       = 5'd22;

endpackage

//--- dataReg.sv
`timescale 1ns/100ps

module dataReg #(
        parameter type payloadT = busPkg::wordT
) (
        input  logic    Clock,
        input  logic    rstN,
        input  logic    load,
        input  payloadT d,
        output payloadT q
);

        always_ff @(posedge Clock) begin
                if (!rstN) begin
                        q <= '0;
                end else if (load) begin
                        q <= d;  // Holds until the next load.
                end
        end

endmodule

//--- datapath.f
busPkg.sv
isaPkg.sv
dataReg.sv
mdrUnit.sv
regSelect.sv
busMux.sv
alu.sv
datapath.sv
datapathTb.sv

//--- datapath.sv
`timescale 1ns/100ps

module datapath (
        input  logic                          Clock,
        input  logic                          rstN,
        input  logic                          PCin,
        input  logic                          IRin,
        input  logic                          Yin,
        input  logic                          MARin,
        input  logic                          HIin,
        input  logic                          LOin,
        input  logic                          MDRin,
        input  logic                          Zin,
        input  logic                          PCout,
        input  logic                          MDRout,
        input  logic                          ZHighout,
        input  logic                          Zlowout,
        input  logic                          HIout,
        input  logic                          LOout,
        input  logic                          Cout,
        input  logic                          IncPC,
        input  logic                          Read,
        input  logic                          GRA,
        input  logic                          GRB,
        input  logic                          GRC,
        input  logic                          Rin,
        input  logic                          Rout,
        input  logic                          BAout,
        input  logic [isaPkg::aluOpWidth-1:0] operation,
        input  busPkg::wordT                  Mdatain,
        output busPkg::wordT                  busData,
        output busPkg::wordT                  marData
);

        import busPkg::*;

        wordT                regData [regCount];
        wordT                pcData, pcNext, irData, yData, hiData, loData, mdrData;
        wordT                constExt;
        pairT                zData, aluResult;
        logic [regCount-1:0] regIn, regOut;

        ////////////////////////////////////////////////////////////////////////////
        // Registers on the shared bus
        ////////////////////////////////////////////////////////////////////////////

        for (genvar i = 0; i < regCount; i++) begin : genRegs
                dataReg gpReg (.Clock, .rstN, .load(regIn[i]), .d(busData), .q(regData[i]));
        end

        assign pcNext = IncPC ? pcData + 1'b1 : busData;  // Increment path.

        dataReg pcReg  (.Clock, .rstN, .load(PCin),  .d(pcNext),  .q(pcData));
        dataReg irReg  (.Clock, .rstN, .load(IRin),  .d(busData), .q(irData));
        dataReg yReg   (.Clock, .rstN, .load(Yin),   .d(busData), .q(yData));
        dataReg marReg (.Clock, .rstN, .load(MARin), .d(busData), .q(marData));
        dataReg hiReg  (.Clock, .rstN, .load(HIin),  .d(busData), .q(hiData));
        dataReg loReg  (.Clock, .rstN, .load(LOin),  .d(busData), .q(loData));

        dataReg #(.payloadT(pairT)) zReg (.Clock, .rstN, .load(Zin), .d(aluResult), .q(zData));

        mdrUnit mdr (.Clock, .rstN, .MDRin, .Read, .busData, .Mdatain, .mdrData);

        ////////////////////////////////////////////////////////////////////////////
        // Select, bus and ALU
        ////////////////////////////////////////////////////////////////////////////

        regSelect select (
                .irData, .GRA, .GRB, .GRC, .Rin, .Rout, .BAout,
                .regIn, .regOut, .constExt
        );

        busMux mux (
                .regOut, .BAout, .PCout, .MDRout, .ZHighout, .Zlowout, .HIout, .LOout, .Cout,
                .regData, .pcData, .mdrData, .zData, .hiData, .loData, .constExt,
                .busData
        );

        alu aluUnit (.operation, .yData, .busData, .result(aluResult));

        ////////////////////////////////////////////////////////////////////////////
        // Control word checks
        ////////////////////////////////////////////////////////////////////////////

        // One bus driver per cycle, general registers included.
        assert property (@(posedge Clock) disable iff (!rstN)
                $onehot0({PCout, MDRout, ZHighout, Zlowout, HIout, LOout, Cout, |regOut}));

        assert property (@(posedge Clock) disable iff (!rstN)
                $onehot0({GRA, GRB, GRC}));

        // MDR loading from memory while it drives the bus.
        assert property (@(posedge Clock) disable iff (!rstN)
                !(MDRin && Read && MDRout));

endmodule

//--- datapathTb.sv
`timescale 1ns/100ps

module datapathTb;

        import busPkg::*;
        import isaPkg::*;

        typedef struct packed {
                logic PCin, IRin, Yin, MARin, HIin, LOin, MDRin, Zin;
                logic PCout, MDRout, ZHighout, Zlowout, HIout, LOout, Cout;
                logic IncPC, Read, GRA, GRB, GRC, Rin, Rout, BAout;
                logic [aluOpWidth-1:0] operation;
        } ctlT;

        // Output that a row compares.
        localparam logic [1:0] chkNone = 2'd0;
        localparam logic [1:0] chkBus  = 2'd1;
        localparam logic [1:0] chkMar  = 2'd2;

        localparam logic [4:0] ldiOp     = 5'b01000;
        localparam int         maxCycles = 200;

        typedef struct packed {
                ctlT        ctl;
                wordT       mdata;
                logic [1:0] chk;
                wordT       expVal;
        } rowT;

        logic        Clock = 1'b0;
        logic        rstN;
        ctlT         ctl;
        wordT        Mdatain, busData, marData;
        rowT         rows[$];
        wordT        model[regCount];   // Expected general registers.
        wordT        pcModel;
        logic [31:0] seed = 32'd62;
        int          cycle;

        always #20 Clock = ~Clock;

        datapath datapath_inst (
                .Clock, .rstN,
                .PCin(ctl.PCin), .IRin(ctl.IRin), .Yin(ctl.Yin), .MARin(ctl.MARin),
                .HIin(ctl.HIin), .LOin(ctl.LOin), .MDRin(ctl.MDRin), .Zin(ctl.Zin),
                .PCout(ctl.PCout), .MDRout(ctl.MDRout), .ZHighout(ctl.ZHighout),
                .Zlowout(ctl.Zlowout), .HIout(ctl.HIout), .LOout(ctl.LOout),
                .Cout(ctl.Cout), .IncPC(ctl.IncPC), .Read(ctl.Read),
                .GRA(ctl.GRA), .GRB(ctl.GRB), .GRC(ctl.GRC),
                .Rin(ctl.Rin), .Rout(ctl.Rout), .BAout(ctl.BAout),
                .operation(ctl.operation), .Mdatain, .busData, .marData
        );

        function automatic wordT nextRand();
                seed = seed * 32'd1103515245 + 32'd12345;
                return seed ^ (seed >> 13);
        endfunction

        function automatic wordT signExtend(logic [18:0] c);
                return {{13{c[18]}}, c};
        endfunction

        task automatic abortRun(string reason);
                $display("%s", reason);
                $display("Regression failed");
                $fatal(1, "Run stopped");
        endtask

        task automatic checkValue(string what, wordT got, wordT want);
                if (got !== want) begin
                        $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, want);
                        abortRun("A datapath output did not match its expected value");
                end
        endtask

        task automatic addRow(ctlT c, wordT m, logic [1:0] chk, wordT e);
                rowT r;
                r.ctl    = c;
                r.mdata  = m;
                r.chk    = chk;
                r.expVal = e;
                rows.push_back(r);
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Table builders
        ////////////////////////////////////////////////////////////////////////////

        task automatic fetch(wordT instr);
                addRow('{PCout: 1'b1, MARin: 1'b1, default: '0}, '0, chkBus, pcModel);
                addRow('{IncPC: 1'b1, PCin: 1'b1, default: '0}, '0, chkMar, pcModel);
                pcModel = pcModel + 32'd1;
                addRow('{Read: 1'b1, MDRin: 1'b1, default: '0}, instr, chkNone, '0);
                addRow('{MDRout: 1'b1, IRin: 1'b1, default: '0}, '0, chkBus, instr);
        endtask

        task automatic ldi(logic [3:0] ra, logic [3:0] rb, logic [18:0] c);
                wordT base, sum;
                base = (rb == 4'd0) ? '0 : model[rb];  // R0 is zero as a base.
                sum  = base + signExtend(c);
                fetch({ldiOp, ra, rb, c});
                addRow('{GRB: 1'b1, BAout: 1'b1, Yin: 1'b1, default: '0}, '0, chkBus, base);
                addRow('{Cout: 1'b1, Zin: 1'b1, operation: aluOpAdd, default: '0},
                       '0, chkBus, signExtend(c));
                addRow('{Zlowout: 1'b1, GRA: 1'b1, Rin: 1'b1, default: '0}, '0, chkBus, sum);
                addRow('{GRA: 1'b1, Rout: 1'b1, default: '0}, '0, chkBus, sum);
                model[ra] = sum;
        endtask

        task automatic aluCheck(logic [aluOpWidth-1:0] op);
                wordT a, b, low;
                a = nextRand();
                b = nextRand();
                case (op)
                        aluOpAnd: low = a & b;
                        aluOpOr:  low = a | b;
                        aluOpSub: low = a - b;
                        aluOpShr: low = a >> b[4:0];
                        aluOpShl: low = a << b[4:0];
                        aluOpNeg: low = 32'd0 - b;
                        default:  low = ~b;
                endcase
                addRow('{Read: 1'b1, MDRin: 1'b1, default: '0}, a, chkNone, '0);
                addRow('{MDRout: 1'b1, Yin: 1'b1, default: '0}, '0, chkBus, a);
                addRow('{Read: 1'b1, MDRin: 1'b1, default: '0}, b, chkNone, '0);
                addRow('{MDRout: 1'b1, Zin: 1'b1, operation: op, default: '0}, '0, chkBus, b);
                addRow('{Zlowout: 1'b1, default: '0}, '0, chkBus, low);
                addRow('{ZHighout: 1'b1, default: '0}, '0, chkBus, {32{low[31]}});
        endtask

        task automatic buildTable();
                logic [aluOpWidth-1:0] ops [7];
                wordT                  r;
                ops = '{aluOpAnd, aluOpOr, aluOpSub, aluOpShl, aluOpShr, aluOpNeg, aluOpNot};
                foreach (model[i]) model[i] = '0;
                pcModel = '0;
                addRow('{default: '0}, '0, chkMar, '0);
                r = nextRand();
                ldi(4'd3, 4'd0, r[18:0]);
                r = nextRand();
                ldi(4'd0, 4'd0, r[18:0]);   // R0 no longer zero.
                r = nextRand();
                ldi(4'd5, 4'd0, r[18:0]);
                r = nextRand();
                ldi(4'd6, 4'd5, r[18:0]);
                // The rc field is the top of C.
                addRow('{GRC: 1'b1, Rout: 1'b1, default: '0}, '0, chkBus, model[r[18:15]]);
                // MAR path, then an idle bus.
                addRow('{GRA: 1'b1, Rout: 1'b1, MARin: 1'b1, default: '0}, '0, chkBus, model[6]);
                addRow('{default: '0}, '0, chkMar, model[6]);
                addRow('{default: '0}, '0, chkBus, '0);
                // HI takes ra, LO takes rb.
                addRow('{GRA: 1'b1, Rout: 1'b1, HIin: 1'b1, default: '0}, '0, chkBus, model[6]);
                addRow('{GRB: 1'b1, Rout: 1'b1, LOin: 1'b1, default: '0}, '0, chkBus, model[5]);
                addRow('{HIout: 1'b1, default: '0}, '0, chkBus, model[6]);
                addRow('{LOout: 1'b1, default: '0}, '0, chkBus, model[5]);
                foreach (ops[i]) aluCheck(ops[i]);
        endtask

        task automatic replay();
                foreach (rows[i]) begin
                        @(posedge Clock);
                        ctl     <= rows[i].ctl;
                        Mdatain <= rows[i].mdata;
                        @(negedge Clock);   // Mid-cycle sample.
                        cycle++;
                        if (cycle > maxCycles) abortRun("Stimulus table ran past its cycle limit");
                        if (rows[i].chk == chkBus) checkValue("busData", busData, rows[i].expVal);
                        if (rows[i].chk == chkMar) checkValue("marData", marData, rows[i].expVal);
                end
        endtask

        initial begin
                int waitCycles;
                rstN    = 1'b0;
                ctl     = '0;
                Mdatain = '0;
                cycle   = 0;
                buildTable();
                waitCycles = 0;
                while (waitCycles < 2) begin
                        @(posedge Clock);
                        waitCycles++;
                end
                rstN <= 1'b1;
                waitCycles = 0;
                while (marData !== '0) begin
                        @(posedge Clock);
                        waitCycles++;
                        if (waitCycles > 4) abortRun("MAR did not clear after reset");
                end
                replay();
                $display("Regression passed");
                $finish;
        end

endmodule

//--- isaPkg.sv
package isaPkg;

        ////////////////////////////////////////////////////////////////////////////
        // Instruction register fields
        ////////////////////////////////////////////////////////////////////////////

        localparam int fieldWidth = 4;                // One register field.
        localparam int opMsb      = 31;
        localparam int opLsb      = opMsb - 4;        // Five opcode bits.
        localparam int raMsb      = opLsb - 1;
        localparam int rbMsb      = raMsb - fieldWidth;
        localparam int rcMsb      = rbMsb - fieldWidth;
        localparam int constWidth = rcMsb + 1;        // C takes bits 18 down to 0.

        ////////////////////////////////////////////////////////////////////////////
        // ALU operation codes
        ////////////////////////////////////////////////////////////////////////////

        localparam int aluOpWidth = 5;

        localparam logic [aluOpWidth-1:0] aluOpAdd = 5'b00011;
        localparam logic [aluOpWidth-1:0] aluOpSub = 5'b00100;
        localparam logic [aluOpWidth-1:0] aluOpShr = 5'b00101;
        localparam logic [aluOpWidth-1:0] aluOpShl = 5'b00111;
        localparam logic [aluOpWidth-1:0] aluOpAnd = 5'b01010;
        localparam logic [aluOpWidth-1:0] aluOpOr  = 5'b01011;
        localparam logic [aluOpWidth-1:0] aluOpNeg = 5'b10001;
        localparam logic [aluOpWidth-1:0] aluOpNot = 5'b10010;

endpackage

//--- mdrUnit.sv
`timescale 1ns/100ps

module mdrUnit (
        input  logic         Clock,
        input  logic         rstN,
        input  logic         MDRin,
        input  logic         Read,
        input  busPkg::wordT busData,
        input  busPkg::wordT Mdatain,
        output busPkg::wordT mdrData
);

        import busPkg::*;

        wordT nextData;

        // Memory word on a read, bus word otherwise.
        assign nextData = Read ? Mdatain : busData;

        dataReg #(
                .payloadT(wordT)
        ) mdrReg (
                .Clock(Clock),
                .rstN (rstN),
                .load (MDRin),
                .d    (nextData),
                .q    (mdrData)
        );

endmodule

//--- regSelect.sv
`timescale 1ns/100ps

module regSelect (
        input  busPkg::wordT                  irData,
        input  logic                          GRA,
        input  logic                          GRB,
        input  logic                          GRC,
        input  logic                          Rin,
        input  logic                          Rout,
        input  logic                          BAout,
        output logic [busPkg::regCount-1:0]   regIn,
        output logic [busPkg::regCount-1:0]   regOut,
        output busPkg::wordT                  constExt
);

        import busPkg::*;
        import isaPkg::*;

        logic [fieldWidth-1:0] field;
        logic                  fieldValid;
        logic [regCount-1:0]   decoded;

        ////////////////////////////////////////////////////////////////////////////
        // Field select and 4-to-16 decode
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                field      = '0;
                fieldValid = 1'b1;
                if (GRA) begin
                        field = irData[raMsb -: fieldWidth];
                end else if (GRB) begin
                        field = irData[rbMsb -: fieldWidth];
                end else if (GRC) begin
                        field = irData[rcMsb -: fieldWidth];
                end else begin
                        fieldValid = 1'b0;  // No field, no register.
                end
        end

        assign decoded = fieldValid ? (regCount'(1) << field) : '0;

        assign regIn  = decoded & {regCount{Rin}};
        assign regOut = decoded & {regCount{Rout | BAout}};  // Bus mux zeroes R0 on BAout.

        // Sign-extended C field.
        assign constExt = {{(wordWidth - constWidth){irData[constWidth-1]}},
                           irData[constWidth-1:0]};

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the datapath testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module datapathTb \
        -f datapath.f -Mdir obj_dir
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

./obj_dir/VdatapathTb
status=$?
if [ $status -ne 0 ]; then
        echo "Simulation failed with status $status"
        exit $status
fi
exit 0
